//--- all.f
+incdir+.
rv_decode_pkg.sv
rv_imm_gen.sv
rv_system_decode.sv
rv_ctrl_decode.sv
rv_decode.sv
tb_rv_decode.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_rv_decode
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_rv_decode.sv
/*
 * Directed testbench for the RV32I decode stage. Each test task sends
 * words through the DUT and checks the registered decode one cycle later
 * against values rebuilt from the RV32I encoding rules.
 */
`default_nettype none
`timescale 1ns/100ps

`include "rv_decode_macros.svh"

module tb_rv_decode import rv_decode_pkg::*;
;

    localparam int CYCLE_LIMIT = 2000;      // Tests need about 420 cycles

    logic                   clk_i, rst_n_i, instr_valid_i;
    rv_instr_u              instr_i;
    logic                   valid_o, illegal_instr_o, jump_en_o, rf_we_o;
    logic                   a_op_sel_o, b_op_sel_o, cmp_b_op_sel_o;
    logic                   load_store_o, mem_we_o, csr_we_o;
    logic [`REG_IDX_W-1:0]  rd_sel_o, rs1_sel_o, rs2_sel_o;
    logic [`XLEN-1:0]       imm_o;
    logic [`FUNCT3_W-1:0]   mem_width_o;
    logic [`CMP_FUNC_W-1:0] cmp_type_o;
    logic [`RF_DIN_W-1:0]   rf_din_sel_o;
    logic [`ALU_FUNC_W-1:0] alu_op_sel_o;
    int                     errors, checks, cycles;

    rv_decode uut (.*);

    initial
    begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    initial
    begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT)
        begin
            @(posedge clk_i);
            cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks and stimulus helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_code(input string name, input logic [`CMP_FUNC_W-1:0] exp,
                              input logic [`CMP_FUNC_W-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] exp,
                              input logic [`XLEN-1:0] act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("FAILED %s: expected %h, got %h", name, exp, act);
        end
    endtask

    task automatic check_enables(input logic ill, input logic jmp, input logic rfwe,
                                 input logic memwe, input logic csrwe);
        check_bit("illegal_instr_o", ill, illegal_instr_o);
        check_bit("jump_en_o", jmp, jump_en_o);
        check_bit("rf_we_o", rfwe, rf_we_o);
        check_bit("mem_we_o", memwe, mem_we_o);
        check_bit("csr_we_o", csrwe, csr_we_o);
    endtask

    task automatic check_idle();
        check_bit("valid_o", 1'b0, valid_o);
        check_enables(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    function automatic rv_instr_u make_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [6:0] opc);
        rv_instr_u w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = opc;
        return w;
    endfunction

    function automatic logic known_opcode(input logic [6:0] opc);
        case (opc)
            `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR, `OPC_BRANCH,
            `OPC_LOAD, `OPC_STORE, `OPC_OP_IMM, `OPC_OP, `OPC_SYSTEM:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // One word in, then a bubble. The bubble after the previous word
    // is checked while the new word goes in
    task automatic send(input rv_instr_u w);
        @(posedge clk_i);
        instr_i       <= w;
        instr_valid_i <= 1'b1;
        @(negedge clk_i);
        check_idle();
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
        @(negedge clk_i);
        check_bit("valid_o", 1'b1, valid_o);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_test();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        check_idle();                       // Inside reset
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        check_idle();
    endtask

    task automatic alu_test();
        logic [31:0]            r;
        logic [6:0]             opc, f7;
        logic [2:0]             f3;
        logic                   ill, imm_form;
        logic [`ALU_FUNC_W-1:0] exp_alu;
        logic [`CMP_FUNC_W-1:0] exp_cmp;
        logic [`RF_DIN_W-1:0]   exp_din;
        for (int o = 0; o < 2; o++)
        begin
            for (int k = 0; k < 24; k++)
            begin
                r        = $urandom;
                opc      = (o == 0) ? `OPC_OP : `OPC_OP_IMM;
                f3       = k[2:0];
                f7       = (k < 8) ? `FUNCT7_BASE : (k < 16) ? `FUNCT7_ALT : 7'h01;
                imm_form = (opc == `OPC_OP_IMM);
                // funct7 is immediate bits except for the shift immediates
                if (imm_form && f3 != 3'd1 && f3 != 3'd5)
                    ill = 1'b0;
                else if (f7 == `FUNCT7_BASE)
                    ill = 1'b0;
                else if (f7 == `FUNCT7_ALT)
                    ill = !(f3 == 3'd5 || (f3 == 3'd0 && !imm_form));
                else
                    ill = 1'b1;
                exp_alu = `ALU_FUNC_ADD;
                exp_din = `RF_DIN_ALU;
                case (f3)
                    3'd0:    if (!imm_form && f7 == `FUNCT7_ALT) exp_alu = `ALU_FUNC_SUB;
                    3'd1:    exp_alu = `ALU_FUNC_SLL;
                    3'd2,
                    3'd3:    exp_din = `RF_DIN_CMP;
                    3'd4:    exp_alu = `ALU_FUNC_XOR;
                    3'd5:    exp_alu = (f7 == `FUNCT7_ALT) ? `ALU_FUNC_SRA : `ALU_FUNC_SRL;
                    3'd6:    exp_alu = `ALU_FUNC_OR;
                    default: exp_alu = `ALU_FUNC_AND;
                endcase
                exp_cmp = (f3 == 3'd2) ? `CMP_FUNC_LT :
                          (f3 == 3'd3) ? `CMP_FUNC_LTU : `CMP_FUNC_UN;
                send(make_word(f7, r[24:20], r[19:15], f3, r[11:7], opc));
                check_enables(ill, 1'b0, !ill, 1'b0, 1'b0);
                check_word("rd_sel_o", {27'd0, r[11:7]}, {27'd0, rd_sel_o});
                check_word("rs1_sel_o", {27'd0, r[19:15]}, {27'd0, rs1_sel_o});
                check_word("rs2_sel_o", {27'd0, r[24:20]}, {27'd0, rs2_sel_o});
                if (!ill)
                begin
                    check_code("alu_op_sel_o", exp_alu, alu_op_sel_o);
                    check_code("cmp_type_o", exp_cmp, cmp_type_o);
                    check_code("rf_din_sel_o", exp_din, rf_din_sel_o);
                    check_bit("a_op_sel_o", 1'b0, a_op_sel_o);
                    check_bit("b_op_sel_o", imm_form, b_op_sel_o);
                    // SLTI and SLTIU compare against the immediate
                    check_bit("cmp_b_op_sel_o", imm_form && (f3 == 3'd2 || f3 == 3'd3),
                              cmp_b_op_sel_o);
                end
            end
        end
    endtask

    task automatic imm_test();
        logic [31:0]      b;
        logic [`XLEN-1:0] exp;
        for (int n = 0; n < 100; n++)
        begin
            b = $urandom;
            case (n % 5)
                0:
                begin
                    b[6:0] = `OPC_JALR;
                    exp    = {{20{b[31]}}, b[31:20]};
                end
                1:
                begin
                    b[6:0] = `OPC_STORE;
                    exp    = {{20{b[31]}}, b[31:25], b[11:7]};
                end
                2:
                begin
                    b[6:0] = `OPC_BRANCH;
                    exp    = {{19{b[31]}}, b[31], b[7], b[30:25], b[11:8], 1'b0};
                end
                3:
                begin
                    b[6:0] = `OPC_LUI;
                    exp    = {b[31:12], 12'd0};
                end
                default:
                begin
                    b[6:0] = `OPC_JAL;
                    exp    = {{11{b[31]}}, b[31], b[19:12], b[20], b[30:21], 1'b0};
                end
            endcase
            send(b);
            check_word("imm_o", exp, imm_o);
        end
    endtask

    task automatic branch_test();
        logic [31:0]            r;
        logic [2:0]             f3;
        logic                   ill;
        logic [`CMP_FUNC_W-1:0] exp_cmp;
        for (int k = 0; k < 8; k++)
        begin
            r   = $urandom;
            f3  = k[2:0];
            ill = (f3 == 3'd2 || f3 == 3'd3);
            case (f3)
                3'd0:    exp_cmp = `CMP_FUNC_EQ;
                3'd1:    exp_cmp = `CMP_FUNC_NQ;
                3'd4:    exp_cmp = `CMP_FUNC_LT;
                3'd5:    exp_cmp = `CMP_FUNC_GE;
                3'd6:    exp_cmp = `CMP_FUNC_LTU;
                default: exp_cmp = `CMP_FUNC_GEU;
            endcase
            send(make_word(r[31:25], r[24:20], r[19:15], f3, r[11:7], `OPC_BRANCH));
            check_enables(ill, !ill, 1'b0, 1'b0, 1'b0);
            if (!ill)
            begin
                check_code("cmp_type_o", exp_cmp, cmp_type_o);
                check_bit("a_op_sel_o", 1'b1, a_op_sel_o);      // PC + imm target
                check_bit("b_op_sel_o", 1'b1, b_op_sel_o);
                check_bit("cmp_b_op_sel_o", 1'b0, cmp_b_op_sel_o);  // rs1 against rs2
            end
        end
        for (int j = 0; j < 2; j++)             // JAL, then JALR
        begin
            r  = $urandom;
            f3 = (j == 0) ? r[14:12] : 3'd0;
            send(make_word(r[31:25], r[24:20], r[19:15], f3, r[11:7],
                           (j == 0) ? `OPC_JAL : `OPC_JALR));
            check_enables(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
            check_code("cmp_type_o", `CMP_FUNC_UN, cmp_type_o);
            check_code("rf_din_sel_o", `RF_DIN_PC4, rf_din_sel_o);
            // JAL adds to the PC, JALR to rs1
            check_bit("a_op_sel_o", (j == 0), a_op_sel_o);
            check_bit("b_op_sel_o", 1'b1, b_op_sel_o);
        end
    endtask

    task automatic mem_test();
        logic [31:0] r;
        logic [2:0]  f3;
        logic        ill;
        for (int s = 0; s < 2; s++)             // Loads, then stores
        begin
            for (int k = 0; k < 8; k++)
            begin
                r   = $urandom;
                f3  = k[2:0];
                ill = (s == 0) ? (f3 == 3'd3 || f3 == 3'd6 || f3 == 3'd7) : (f3 > 3'd2);
                send(make_word(r[31:25], r[24:20], r[19:15], f3, r[11:7],
                               (s == 0) ? `OPC_LOAD : `OPC_STORE));
                check_enables(ill, 1'b0, (s == 0) && !ill, (s == 1) && !ill, 1'b0);
                check_code("mem_width_o", f3, mem_width_o);
                check_bit("load_store_o", 1'b1, load_store_o);
                if (s == 0 && !ill)
                    check_code("rf_din_sel_o", `RF_DIN_MEM, rf_din_sel_o);
            end
        end
    endtask

    task automatic sys_test();
        logic [31:0] r;
        logic [31:0] priv_words [4];
        logic [6:0]  opc;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        ill;
        // ECALL, EBREAK, MRET, WFI
        priv_words = '{32'h00000073, 32'h00100073, 32'h30200073, 32'h10500073};
        for (int k = 0; k < 16; k++)
        begin
            r   = $urandom;
            f3  = k[2:0];
            rd  = (k < 8) ? 5'd0 : (r[11:7] | 5'd1);
            ill = (f3 == 3'd0 || f3 == 3'd4);
            send(make_word(r[31:25], r[24:20], r[19:15], f3, rd, `OPC_SYSTEM));
            check_enables(ill, 1'b0, !ill && rd != 5'd0, 1'b0, !ill);
            if (!ill && rd != 5'd0)
                check_code("rf_din_sel_o", `RF_DIN_CSR, rf_din_sel_o);
        end
        for (int p = 0; p < 4; p++)
        begin
            send(priv_words[p]);
            check_enables(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        end
        for (int u = 0; u < 4; u++)
        begin
            r   = $urandom;
            opc = r[6:0];
            if (known_opcode(opc))
                opc = 7'b1111111;
            r[6:0] = opc;
            send(r);
            check_enables(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        end
    endtask

    initial
    begin
        logic [31:0] seed_ret;
        errors        = 0;
        checks        = 0;
        seed_ret      = $urandom(32'ha89c);
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;

        reset_test();
        alu_test();
        imm_test();
        branch_test();
        mem_test();
        sys_test();

        @(posedge clk_i);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- rv_decode.sv
/*
 * RV32I decode stage. Decodes one word per cycle and registers the result,
 * one cycle of latency and no back-pressure. Enables and the illegal
 * flag are low whenever valid_o is low.
 */
`default_nettype none
`timescale 1ns/100ps

`include "rv_decode_macros.svh"

module rv_decode import rv_decode_pkg::*;
(
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    instr_valid_i,
    input  rv_instr_u               instr_i,
    output logic                    valid_o,
    output logic [`REG_IDX_W-1:0]   rd_sel_o,
    output logic [`REG_IDX_W-1:0]   rs1_sel_o,
    output logic [`REG_IDX_W-1:0]   rs2_sel_o,
    output logic [`XLEN-1:0]        imm_o,
    output logic [`FUNCT3_W-1:0]    mem_width_o,
    output logic                    illegal_instr_o,
    output logic                    jump_en_o,
    output logic [`CMP_FUNC_W-1:0]  cmp_type_o,
    output logic                    rf_we_o,
    output logic [`RF_DIN_W-1:0]    rf_din_sel_o,
    output logic                    a_op_sel_o,
    output logic                    b_op_sel_o,
    output logic                    cmp_b_op_sel_o,
    output logic [`ALU_FUNC_W-1:0]  alu_op_sel_o,
    output logic                    load_store_o,
    output logic                    mem_we_o,
    output logic                    csr_we_o
);

    ////////////////////////////////////////////////////////////////////////
    // Combinational decode
    ////////////////////////////////////////////////////////////////////////
    logic                   sys_illegal, sys_csr_we, sys_rf_we;
    logic                   dec_illegal, dec_jump_en, dec_rf_we;
    logic                   dec_a_op_sel, dec_b_op_sel, dec_cmp_b_op_sel;
    logic                   dec_load_store, dec_mem_we, dec_csr_we;
    logic [`CMP_FUNC_W-1:0] dec_cmp_type;
    logic [`RF_DIN_W-1:0]   dec_rf_din_sel;
    logic [`ALU_FUNC_W-1:0] dec_alu_op_sel;
    logic [`IMM_TYPE_W-1:0] imm_format;
    logic [`XLEN-1:0]       imm;

    rv_system_decode u_sys
    (
        .instr_i(instr_i), .sys_illegal_o(sys_illegal),
        .sys_csr_we_o(sys_csr_we), .sys_rf_we_o(sys_rf_we)
    );

    rv_ctrl_decode u_ctrl
    (
        .instr_i(instr_i), .sys_illegal_i(sys_illegal),
        .sys_csr_we_i(sys_csr_we), .sys_rf_we_i(sys_rf_we),
        .illegal_o(dec_illegal), .jump_en_o(dec_jump_en),
        .cmp_type_o(dec_cmp_type), .rf_we_o(dec_rf_we),
        .rf_din_sel_o(dec_rf_din_sel), .a_op_sel_o(dec_a_op_sel),
        .b_op_sel_o(dec_b_op_sel), .cmp_b_op_sel_o(dec_cmp_b_op_sel),
        .alu_op_sel_o(dec_alu_op_sel), .load_store_o(dec_load_store),
        .mem_we_o(dec_mem_we), .csr_we_o(dec_csr_we),
        .imm_format_o(imm_format)
    );

    rv_imm_gen u_imm
    (
        .instr_i(instr_i), .imm_format_i(imm_format), .imm_o(imm)
    );

    ////////////////////////////////////////////////////////////////////////
    // Pipeline register
    ////////////////////////////////////////////////////////////////////////
    logic illegal_q, jump_en_q, rf_we_q, mem_we_q, csr_we_q;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            valid_o        <= 1'b0;
            rd_sel_o       <= '0;
            rs1_sel_o      <= '0;
            rs2_sel_o      <= '0;
            imm_o          <= '0;
            mem_width_o    <= '0;
            cmp_type_o     <= '0;
            rf_din_sel_o   <= '0;
            a_op_sel_o     <= 1'b0;
            b_op_sel_o     <= 1'b0;
            cmp_b_op_sel_o <= 1'b0;
            alu_op_sel_o   <= '0;
            load_store_o   <= 1'b0;
            illegal_q      <= 1'b0;
            jump_en_q      <= 1'b0;
            rf_we_q        <= 1'b0;
            mem_we_q       <= 1'b0;
            csr_we_q       <= 1'b0;
        end
        else
        begin
            valid_o        <= instr_valid_i;
            rd_sel_o       <= instr_i.r.rd;
            rs1_sel_o      <= instr_i.r.rs1;
            rs2_sel_o      <= instr_i.r.rs2;
            imm_o          <= imm;
            mem_width_o    <= instr_i.r.funct3;    // Load/store width
            cmp_type_o     <= dec_cmp_type;
            rf_din_sel_o   <= dec_rf_din_sel;
            a_op_sel_o     <= dec_a_op_sel;
            b_op_sel_o     <= dec_b_op_sel;
            cmp_b_op_sel_o <= dec_cmp_b_op_sel;
            alu_op_sel_o   <= dec_alu_op_sel;
            load_store_o   <= dec_load_store;
            illegal_q      <= dec_illegal;
            jump_en_q      <= dec_jump_en;
            rf_we_q        <= dec_rf_we;
            mem_we_q       <= dec_mem_we;
            csr_we_q       <= dec_csr_we;
        end
    end

    // Bubble when valid is low
    assign illegal_instr_o = valid_o & illegal_q;
    assign jump_en_o       = valid_o & jump_en_q;
    assign rf_we_o         = valid_o & rf_we_q;
    assign mem_we_o        = valid_o & mem_we_q;
    assign csr_we_o        = valid_o & csr_we_q;

endmodule

`default_nettype wire

//--- rv_ctrl_decode.sv
/*
 * Main opcode decode. Turns an RV32I word into the control word for the
 * execute stage and picks the immediate format. SYSTEM words take their
 * results from the SYSTEM decoder.
 */
`default_nettype none
`timescale 1ns/100ps

`include "rv_decode_macros.svh"

module rv_ctrl_decode import rv_decode_pkg::*;
(
    input  rv_instr_u               instr_i,
    input  logic                    sys_illegal_i,
    input  logic                    sys_csr_we_i,
    input  logic                    sys_rf_we_i,
    output logic                    illegal_o,
    output logic                    jump_en_o,
    output logic [`CMP_FUNC_W-1:0]  cmp_type_o,
    output logic                    rf_we_o,
    output logic [`RF_DIN_W-1:0]    rf_din_sel_o,
    output logic                    a_op_sel_o,     // 1 selects PC
    output logic                    b_op_sel_o,     // 1 selects immediate
    output logic                    cmp_b_op_sel_o,
    output logic [`ALU_FUNC_W-1:0]  alu_op_sel_o,
    output logic                    load_store_o,
    output logic                    mem_we_o,
    output logic                    csr_we_o,
    output logic [`IMM_TYPE_W-1:0]  imm_format_o
);

    logic [`OPCODE_W-1:0] opc;
    logic [`FUNCT3_W-1:0] f3;
    logic [`FUNCT7_W-1:0] f7;
    logic                 is_imm;
    logic                 alt;

    assign opc    = instr_i.r.opcode;
    assign f3     = instr_i.r.funct3;
    assign f7     = instr_i.r.funct7;
    assign is_imm = (opc == `OPC_OP_IMM);
    assign alt    = (f7 == `FUNCT7_ALT);

    always_comb
    begin
        illegal_o      = 1'b0;
        jump_en_o      = 1'b0;
        cmp_type_o     = `CMP_FUNC_UN;
        rf_we_o        = 1'b0;
        rf_din_sel_o   = `RF_DIN_IMM;
        a_op_sel_o     = 1'b0;
        b_op_sel_o     = 1'b0;
        cmp_b_op_sel_o = 1'b0;
        alu_op_sel_o   = `ALU_FUNC_ADD;
        load_store_o   = 1'b0;
        mem_we_o       = 1'b0;
        csr_we_o       = 1'b0;
        imm_format_o   = `IMM_TYPE_I;

        case (opc)
            `OPC_LUI:
            begin
                rf_we_o      = 1'b1;
                imm_format_o = `IMM_TYPE_U;
            end
            `OPC_AUIPC, `OPC_JAL:
            begin
                rf_we_o      = 1'b1;
                rf_din_sel_o = (opc == `OPC_JAL) ? `RF_DIN_PC4 : `RF_DIN_ALU;
                jump_en_o    = (opc == `OPC_JAL);
                a_op_sel_o   = 1'b1;
                b_op_sel_o   = 1'b1;
                imm_format_o = (opc == `OPC_JAL) ? `IMM_TYPE_J : `IMM_TYPE_U;
            end
            `OPC_JALR:
            begin
                illegal_o    = (f3 != 3'b000);
                jump_en_o    = 1'b1;
                rf_we_o      = 1'b1;
                rf_din_sel_o = `RF_DIN_PC4;
                b_op_sel_o   = 1'b1;
            end
            `OPC_BRANCH:
            begin
                jump_en_o    = 1'b1;
                a_op_sel_o   = 1'b1;    // Target is PC + imm
                b_op_sel_o   = 1'b1;
                imm_format_o = `IMM_TYPE_B;
                case (f3)
                    3'b000:  cmp_type_o = `CMP_FUNC_EQ;
                    3'b001:  cmp_type_o = `CMP_FUNC_NQ;
                    3'b100:  cmp_type_o = `CMP_FUNC_LT;
                    3'b101:  cmp_type_o = `CMP_FUNC_GE;
                    3'b110:  cmp_type_o = `CMP_FUNC_LTU;
                    3'b111:  cmp_type_o = `CMP_FUNC_GEU;
                    default: illegal_o  = 1'b1;
                endcase
            end
            `OPC_LOAD:
            begin
                illegal_o    = (f3 == 3'b011) || (f3[2:1] == 2'b11);
                rf_we_o      = 1'b1;
                rf_din_sel_o = `RF_DIN_MEM;
                b_op_sel_o   = 1'b1;
                load_store_o = 1'b1;
            end
            `OPC_STORE:
            begin
                illegal_o    = f3[2] || (f3[1:0] == 2'b11);
                b_op_sel_o   = 1'b1;
                load_store_o = 1'b1;
                mem_we_o     = 1'b1;
                imm_format_o = `IMM_TYPE_S;
            end
            `OPC_OP_IMM, `OPC_OP:
            begin
                rf_we_o      = 1'b1;
                rf_din_sel_o = `RF_DIN_ALU;
                b_op_sel_o   = is_imm;
                case (f3)
                    3'b000:  alu_op_sel_o = (alt && !is_imm) ? `ALU_FUNC_SUB : `ALU_FUNC_ADD;
                    3'b001:  alu_op_sel_o = `ALU_FUNC_SLL;
                    3'b010, 3'b011:
                    begin
                        // SLT(I) and SLT(I)U go through the comparator
                        cmp_type_o     = f3[0] ? `CMP_FUNC_LTU : `CMP_FUNC_LT;
                        rf_din_sel_o   = `RF_DIN_CMP;
                        cmp_b_op_sel_o = is_imm;
                    end
                    3'b100:  alu_op_sel_o = `ALU_FUNC_XOR;
                    3'b101:  alu_op_sel_o = alt ? `ALU_FUNC_SRA : `ALU_FUNC_SRL;
                    3'b110:  alu_op_sel_o = `ALU_FUNC_OR;
                    default: alu_op_sel_o = `ALU_FUNC_AND;
                endcase
                // funct7 only matters for OP and the shift immediates
                if (!is_imm || f3 == 3'b001 || f3 == 3'b101)
                    illegal_o = !((f7 == `FUNCT7_BASE)
                                  || (alt && (f3 == 3'b000 || f3 == 3'b101)));
            end
            `OPC_SYSTEM:
            begin
                illegal_o    = sys_illegal_i;
                csr_we_o     = sys_csr_we_i;
                rf_we_o      = sys_rf_we_i;
                rf_din_sel_o = `RF_DIN_CSR;
            end
            default:
                illegal_o = 1'b1;
        endcase

        // Nothing may write or jump on an illegal word
        if (illegal_o)
        begin
            jump_en_o = 1'b0;
            rf_we_o   = 1'b0;
            mem_we_o  = 1'b0;
            csr_we_o  = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rv_system_decode.sv
/*
 * SYSTEM branch of the decoder. Looks only at the fields of the word;
 * the caller qualifies the results with the SYSTEM opcode.
 */
`default_nettype none
`timescale 1ns/100ps

module rv_system_decode import rv_decode_pkg::*;
(
    input  rv_instr_u   instr_i,
    output logic        sys_illegal_o,
    output logic        sys_csr_we_o,
    output logic        sys_rf_we_o
);

    logic priv_word;
    logic rd_nonzero;

    // rd, rs1 and funct3 all zero: ECALL, EBREAK, MRET, WFI or unknown
    assign priv_word  = (instr_i.i.rd == '0) && (instr_i.i.rs1 == '0)
                        && (instr_i.i.funct3 == '0);
    assign rd_nonzero = (instr_i.i.rd != '0);

    always_comb
    begin
        sys_illegal_o = 1'b0;
        sys_csr_we_o  = 1'b0;
        sys_rf_we_o   = 1'b0;

        if (priv_word)
        begin
            sys_illegal_o = 1'b1;   // No trap support in this core
        end
        else
        begin
            case (instr_i.i.funct3)
                3'b001, 3'b010, 3'b011,
                3'b101, 3'b110, 3'b111:
                begin
                    // CSRRW/S/C and immediate forms
                    sys_csr_we_o = 1'b1;
                    sys_rf_we_o  = rd_nonzero;
                end
                default:
                    sys_illegal_o = 1'b1;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rv_imm_gen.sv
/*
 * Immediate generator. Rebuilds the sign-extended 32-bit immediate of an
 * I, S, B, U or J format word; other format codes give zero.
 */
`default_nettype none
`timescale 1ns/100ps

`include "rv_decode_macros.svh"

module rv_imm_gen import rv_decode_pkg::*;
(
    input  rv_instr_u               instr_i,
    input  logic [`IMM_TYPE_W-1:0]  imm_format_i,
    output logic [`XLEN-1:0]        imm_o
);

    rv_r_fields_t f;
    logic         sign;

    assign f    = instr_i.r;
    assign sign = f.funct7[6];      // Bit 31 of the word

    always_comb
    begin
        case (imm_format_i)
            `IMM_TYPE_I:
                imm_o = {{20{sign}}, instr_i.i.imm12};
            `IMM_TYPE_S:
                imm_o = {{20{sign}}, f.funct7, f.rd};
            `IMM_TYPE_B:
                imm_o = {{20{sign}}, f.rd[0], f.funct7[5:0], f.rd[4:1], 1'b0};
            `IMM_TYPE_U:
                imm_o = {f.funct7, f.rs2, f.rs1, f.funct3, 12'd0};
            `IMM_TYPE_J:
            begin
                // imm[19:12] sits in rs1/funct3, imm[11] in rs2[0]
                imm_o = {{12{sign}}, f.rs1, f.funct3, f.rs2[0],
                         f.funct7[5:0], f.rs2[4:1], 1'b0};
            end
            default:
                imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rv_decode_pkg.sv
/*
 * Instruction word types of the decode stage. The union lets the same
 * 32-bit word be read as R-type or as I-type fields.
 */
`default_nettype none

`include "rv_decode_macros.svh"

package rv_decode_pkg;

    typedef struct packed {
        logic [`FUNCT7_W-1:0]   funct7;
        logic [`REG_IDX_W-1:0]  rs2;
        logic [`REG_IDX_W-1:0]  rs1;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`OPCODE_W-1:0]   opcode;
    } rv_r_fields_t;

    typedef struct packed {
        logic [11:0]            imm12;
        logic [`REG_IDX_W-1:0]  rs1;
        logic [`FUNCT3_W-1:0]   funct3;
        logic [`REG_IDX_W-1:0]  rd;
        logic [`OPCODE_W-1:0]   opcode;
    } rv_i_fields_t;

    typedef union packed {
        rv_r_fields_t           r;
        rv_i_fields_t           i;
    } rv_instr_u;

endpackage

`default_nettype wire

//--- rv_decode_macros.svh
/*
 * Shared constants of the RV32I decode stage: field widths, opcodes,
 * ALU and comparison function codes, immediate formats and the
 * register-file write source codes. Include wherever a code is needed.
 */
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Widths
////////////////////////////////////////////////////////////////////////////
`define XLEN            32
`define REG_IDX_W       5
`define OPCODE_W        7
`define FUNCT3_W        3
`define FUNCT7_W        7
`define ALU_FUNC_W      3
`define CMP_FUNC_W      3
`define IMM_TYPE_W      3
`define RF_DIN_W        3

////////////////////////////////////////////////////////////////////////////
// RV32I opcodes and funct7 values
////////////////////////////////////////////////////////////////////////////
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_BRANCH      7'b1100011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_OP_IMM      7'b0010011
`define OPC_OP          7'b0110011
`define OPC_SYSTEM      7'b1110011

`define FUNCT7_BASE     7'b0000000
`define FUNCT7_ALT      7'b0100000      // SUB, SRA, SRAI

////////////////////////////////////////////////////////////////////////////
// Function and select codes
////////////////////////////////////////////////////////////////////////////
`define ALU_FUNC_ADD    3'd0
`define ALU_FUNC_SUB    3'd1
`define ALU_FUNC_XOR    3'd2
`define ALU_FUNC_OR     3'd3
`define ALU_FUNC_AND    3'd4
`define ALU_FUNC_SLL    3'd5
`define ALU_FUNC_SRL    3'd6
`define ALU_FUNC_SRA    3'd7

`define CMP_FUNC_EQ     3'd0
`define CMP_FUNC_NQ     3'd1
`define CMP_FUNC_LT     3'd2
`define CMP_FUNC_GE     3'd3
`define CMP_FUNC_LTU    3'd4
`define CMP_FUNC_GEU    3'd5
`define CMP_FUNC_UN     3'd6            // Unconditional

`define IMM_TYPE_I      3'd0
`define IMM_TYPE_S      3'd1
`define IMM_TYPE_B      3'd2
`define IMM_TYPE_U      3'd3
`define IMM_TYPE_J      3'd4

`define RF_DIN_IMM      3'd0
`define RF_DIN_PC4      3'd1
`define RF_DIN_ALU      3'd2
`define RF_DIN_CMP      3'd3
`define RF_DIN_MEM      3'd4
`define RF_DIN_CSR      3'd5

`endif
